//--- src/tx_engine_pkg.sv
// Transmit engine definitions
package tx_engine_pkg;

    localparam int NOC_DATA_W       = 64;
    localparam int CTRL_DATA_W      = 32;
    localparam int BYTES_PER_FLIT   = 8;
    localparam int PADBYTES_W       = 3;
    localparam int FLOWID_W         = 4;
    localparam int NUM_FLOWS        = 16;
    localparam int TX_PAYLOAD_PTR_W = 12;  // Wraps modulo 4096.
    localparam int MSG_SIZE_W       = 9;   // 1 to 256 bytes.
    localparam int MAX_PKT_BYTES    = 64;
    localparam int PKT_BYTES_W      = 7;
    localparam int PKT_FLITS_W      = 4;
    localparam int COORD_W          = 4;

    localparam logic [COORD_W-1:0] SRC_X     = 4'd1;
    localparam logic [COORD_W-1:0] SRC_Y     = 4'd2;
    localparam logic [COORD_W-1:0] DST_BUF_X = 4'd3;
    localparam logic [COORD_W-1:0] DST_BUF_Y = 4'd0;

    localparam int HDR_RSVD_W = NOC_DATA_W - (4 * COORD_W + FLOWID_W + TX_PAYLOAD_PTR_W
                                + PKT_BYTES_W + PADBYTES_W + PKT_FLITS_W);
    localparam int NOTIF_RSVD_W = CTRL_DATA_W - (FLOWID_W + TX_PAYLOAD_PTR_W + MSG_SIZE_W);

    typedef logic [FLOWID_W-1:0]         flowid_t;
    typedef logic [TX_PAYLOAD_PTR_W-1:0] payload_ptr_t;
    typedef logic [MSG_SIZE_W-1:0]       msg_size_t;
    typedef logic [PKT_BYTES_W-1:0]      pkt_bytes_t;
    typedef logic [NOC_DATA_W-1:0]       noc_data_t;
    typedef logic [CTRL_DATA_W-1:0]      ctrl_data_t;

    typedef struct packed {
        flowid_t   flowid;
        msg_size_t size;
    } send_req_t;

    // Header flit of a buffer write packet.
    typedef struct packed {
        logic [COORD_W-1:0]     dst_x;
        logic [COORD_W-1:0]     dst_y;
        logic [COORD_W-1:0]     src_x;
        logic [COORD_W-1:0]     src_y;
        flowid_t                flowid;
        payload_ptr_t           wr_ptr;
        pkt_bytes_t             pkt_bytes;
        logic [PADBYTES_W-1:0]  padbytes;
        logic [PKT_FLITS_W-1:0] data_flits;
        logic [HDR_RSVD_W-1:0]  rsvd;
    } buf_wr_hdr_t;

    typedef struct packed {
        flowid_t                 flowid;
        payload_ptr_t            wr_ptr;  // Pointer after the message.
        msg_size_t               size;
        logic [NOTIF_RSVD_W-1:0] rsvd;
    } tx_notif_t;

    typedef enum logic [2:0] {
        IDLE,
        STATE_RD,
        HDR,
        DATA,
        NOTIF
    } tx_state_e;

    typedef enum logic {
        SEL_HDR,
        SEL_DATA
    } out_mux_sel_e;

endpackage

//--- src/flow_state_table.sv
// Per-flow write pointer table
`timescale 1ns/1ps

module flow_state_table
    import tx_engine_pkg::*;
(
    input  logic         clk,
    input  logic         reset,

    input  logic         rd_req,
    input  flowid_t      rd_flowid,
    output payload_ptr_t rd_ptr,

    input  logic         wr_req,
    input  flowid_t      wr_flowid,
    input  payload_ptr_t wr_ptr
);

    payload_ptr_t ptr_mem [NUM_FLOWS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_FLOWS; i++) begin
                ptr_mem[i] <= '0;  // Every buffer starts at offset zero.
            end
        end else if (wr_req) begin
            ptr_mem[wr_flowid] <= wr_ptr;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
        end else if (rd_req) begin
            rd_ptr <= ptr_mem[rd_flowid];  // One cycle read.
        end
    end

    // The control FSM must finish its write before the next read of a flow.
    assert property (@(posedge clk) disable iff (reset)
        !(rd_req && wr_req && (rd_flowid == wr_flowid)))
        else $error("flow_state_table: read and write of flow %0d in one cycle", rd_flowid);

endmodule

//--- src/tx_engine_datap.sv
// Transmit engine datapath
`timescale 1ns/1ps

module tx_engine_datap
    import tx_engine_pkg::*;
(
    input  logic         clk,
    input  logic         reset,

    input  send_req_t    send_q_rd_data,
    input  payload_ptr_t rd_ptr,
    input  noc_data_t    payload_data,

    input  logic         store_inputs,
    input  logic         store_state,
    input  logic         next_pkt,
    input  logic         flit_taken,
    input  out_mux_sel_e out_mux_sel,

    output flowid_t      cur_flowid,
    output payload_ptr_t new_ptr,
    output noc_data_t    noc_out_data,
    output ctrl_data_t   ctrl_out_data,
    output logic         last_flit,
    output logic         last_pkt
);

    send_req_t              req_reg;
    payload_ptr_t           pkt_ptr;
    msg_size_t              bytes_left;
    logic [PKT_FLITS_W-1:0] flit_cnt;

    pkt_bytes_t             pkt_bytes;
    pkt_bytes_t             pkt_bytes_rnd;
    logic [PKT_FLITS_W-1:0] data_flits;
    logic [PADBYTES_W-1:0]  padbytes;
    buf_wr_hdr_t            hdr;
    tx_notif_t              notif;

    always_ff @(posedge clk) begin
        if (store_inputs) begin
            req_reg <= send_q_rd_data;
        end
        if (store_state) begin
            pkt_ptr <= rd_ptr;
        end else if (next_pkt) begin
            pkt_ptr <= pkt_ptr + payload_ptr_t'(pkt_bytes);  // Wraps at buffer end.
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bytes_left <= '0;
            flit_cnt   <= '0;
        end else begin
            if (store_state) begin
                bytes_left <= req_reg.size;
            end else if (next_pkt) begin
                bytes_left <= bytes_left - msg_size_t'(pkt_bytes);
            end

            if (store_state || next_pkt) begin
                flit_cnt <= '0;
            end else if (flit_taken) begin
                flit_cnt <= flit_cnt + 1'b1;
            end
        end
    end

    // Packet sizing.
    always_comb begin
        if (bytes_left > msg_size_t'(MAX_PKT_BYTES)) begin
            pkt_bytes = pkt_bytes_t'(MAX_PKT_BYTES);
        end else begin
            pkt_bytes = bytes_left[PKT_BYTES_W-1:0];
        end
        pkt_bytes_rnd = pkt_bytes + pkt_bytes_t'(BYTES_PER_FLIT - 1);
        data_flits    = pkt_bytes_rnd[PKT_BYTES_W-1:PADBYTES_W];
        padbytes      = '0 - pkt_bytes[PADBYTES_W-1:0];  // Fill to a whole flit.
    end

    assign last_flit = (flit_cnt == data_flits - 1'b1);
    assign last_pkt  = (bytes_left <= msg_size_t'(MAX_PKT_BYTES));

    always_comb begin
        hdr            = '0;
        hdr.dst_x      = DST_BUF_X;
        hdr.dst_y      = DST_BUF_Y;
        hdr.src_x      = SRC_X;
        hdr.src_y      = SRC_Y;
        hdr.flowid     = req_reg.flowid;
        hdr.wr_ptr     = pkt_ptr;
        hdr.pkt_bytes  = pkt_bytes;
        hdr.padbytes   = padbytes;
        hdr.data_flits = data_flits;
    end

    // By notification time the packet pointer has passed the whole message.
    assign new_ptr    = pkt_ptr;
    assign cur_flowid = req_reg.flowid;

    always_comb begin
        notif        = '0;
        notif.flowid = req_reg.flowid;
        notif.wr_ptr = new_ptr;
        notif.size   = req_reg.size;
    end

    assign ctrl_out_data = notif;
    assign noc_out_data  = (out_mux_sel == SEL_HDR) ? noc_data_t'(hdr) : payload_data;

endmodule

//--- src/tx_engine_ctrl.sv
// Transmit engine control FSM
`timescale 1ns/1ps

module tx_engine_ctrl
    import tx_engine_pkg::*;
(
    input  logic         clk,
    input  logic         reset,

    input  logic         setup_done,

    input  logic         send_q_empty,
    output logic         send_q_rd_req,

    input  logic         payload_val,
    output logic         payload_rdy,

    output logic         noc_out_val,
    input  logic         noc_out_rdy,

    output logic         ctrl_out_val,
    input  logic         ctrl_out_rdy,

    output logic         state_rd_req,
    output logic         state_wr_req,

    output logic         store_inputs,
    output logic         store_state,
    output logic         next_pkt,
    output logic         flit_taken,
    output out_mux_sel_e out_mux_sel,

    input  logic         last_flit,
    input  logic         last_pkt
);

    tx_state_e state_reg;
    tx_state_e state_next;

    always_ff @(posedge clk) begin
        if (reset) begin
            state_reg <= IDLE;
        end else begin
            state_reg <= state_next;
        end
    end

    always_comb begin
        state_next    = state_reg;
        send_q_rd_req = 1'b0;
        payload_rdy   = 1'b0;
        noc_out_val   = 1'b0;
        ctrl_out_val  = 1'b0;
        state_rd_req  = 1'b0;
        state_wr_req  = 1'b0;
        store_inputs  = 1'b0;
        store_state   = 1'b0;
        next_pkt      = 1'b0;
        flit_taken    = 1'b0;
        out_mux_sel   = SEL_HDR;

        case (state_reg)
            IDLE: begin
                if (setup_done && !send_q_empty) begin
                    send_q_rd_req = 1'b1;
                    state_rd_req  = 1'b1;  // Table read uses the queue head flow id.
                    store_inputs  = 1'b1;
                    state_next    = STATE_RD;
                end
            end
            STATE_RD: begin
                store_state = 1'b1;  // Pointer arrives this cycle.
                state_next  = HDR;
            end
            HDR: begin
                noc_out_val = 1'b1;
                if (noc_out_rdy) begin
                    state_next = DATA;
                end
            end
            DATA: begin
                out_mux_sel = SEL_DATA;
                noc_out_val = payload_val;  // Payload word goes straight out.
                payload_rdy = noc_out_rdy;
                if (payload_val && noc_out_rdy) begin
                    flit_taken = 1'b1;
                    if (last_flit) begin
                        next_pkt   = 1'b1;
                        state_next = last_pkt ? NOTIF : HDR;
                    end
                end
            end
            NOTIF: begin
                ctrl_out_val = 1'b1;
                if (ctrl_out_rdy) begin
                    state_wr_req = 1'b1;
                    state_next   = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    // Relies on the payload source holding its valid, as the handshake requires.
    assert property (@(posedge clk) disable iff (reset)
        noc_out_val && !noc_out_rdy |=> noc_out_val)
        else $error("tx_engine_ctrl: noc_out_val dropped under back-pressure");

    assert property (@(posedge clk) disable iff (reset)
        payload_val && !payload_rdy |=> payload_val)
        else $error("tx_engine_ctrl: payload_val dropped before its transfer");

endmodule

//--- src/open_loop_tx_engine.sv
// Open-loop TCP transmit engine
`timescale 1ns/1ps

module open_loop_tx_engine
    import tx_engine_pkg::*;
(
    input  logic       clk,
    input  logic       reset,

    input  logic       setup_done,

    input  logic       send_q_empty,
    input  send_req_t  send_q_rd_data,
    output logic       send_q_rd_req,

    input  logic       payload_val,
    input  noc_data_t  payload_data,
    output logic       payload_rdy,

    output logic       noc_out_val,
    output noc_data_t  noc_out_data,
    input  logic       noc_out_rdy,

    output logic       ctrl_out_val,
    output ctrl_data_t ctrl_out_data,
    input  logic       ctrl_out_rdy
);

    logic         state_rd_req;
    logic         state_wr_req;
    logic         store_inputs;
    logic         store_state;
    logic         next_pkt;
    logic         flit_taken;
    out_mux_sel_e out_mux_sel;
    logic         last_flit;
    logic         last_pkt;

    flowid_t      cur_flowid;
    flowid_t      rd_flowid;
    payload_ptr_t rd_ptr;
    payload_ptr_t new_ptr;

    // The request register is not loaded yet on the pop cycle.
    assign rd_flowid = state_rd_req ? send_q_rd_data.flowid : cur_flowid;

    tx_engine_ctrl u_tx_engine_ctrl (
        .clk           (clk),
        .reset         (reset),
        .setup_done    (setup_done),
        .send_q_empty  (send_q_empty),
        .send_q_rd_req (send_q_rd_req),
        .payload_val   (payload_val),
        .payload_rdy   (payload_rdy),
        .noc_out_val   (noc_out_val),
        .noc_out_rdy   (noc_out_rdy),
        .ctrl_out_val  (ctrl_out_val),
        .ctrl_out_rdy  (ctrl_out_rdy),
        .state_rd_req  (state_rd_req),
        .state_wr_req  (state_wr_req),
        .store_inputs  (store_inputs),
        .store_state   (store_state),
        .next_pkt      (next_pkt),
        .flit_taken    (flit_taken),
        .out_mux_sel   (out_mux_sel),
        .last_flit     (last_flit),
        .last_pkt      (last_pkt)
    );

    tx_engine_datap u_tx_engine_datap (
        .clk            (clk),
        .reset          (reset),
        .send_q_rd_data (send_q_rd_data),
        .rd_ptr         (rd_ptr),
        .payload_data   (payload_data),
        .store_inputs   (store_inputs),
        .store_state    (store_state),
        .next_pkt       (next_pkt),
        .flit_taken     (flit_taken),
        .out_mux_sel    (out_mux_sel),
        .cur_flowid     (cur_flowid),
        .new_ptr        (new_ptr),
        .noc_out_data   (noc_out_data),
        .ctrl_out_data  (ctrl_out_data),
        .last_flit      (last_flit),
        .last_pkt       (last_pkt)
    );

    flow_state_table u_flow_state_table (
        .clk       (clk),
        .reset     (reset),
        .rd_req    (state_rd_req),
        .rd_flowid (rd_flowid),
        .rd_ptr    (rd_ptr),
        .wr_req    (state_wr_req),
        .wr_flowid (cur_flowid),
        .wr_ptr    (new_ptr)
    );

endmodule

//--- verification/open_loop_tx_engine_tb.sv
// Transmit engine testbench
`timescale 1ns/1ps

module open_loop_tx_engine_tb
    import tx_engine_pkg::*;
();

    localparam int NUM_ROWS = 11;

    typedef struct packed {
        flowid_t      flowid;
        msg_size_t    size;
        logic [4:0]   reps;
        logic         stall;
        payload_ptr_t exp_ptr;  // Pointer after the row's last message.
    } row_t;

    row_t rows [NUM_ROWS] = '{
        '{4'd1,  9'd20,  5'd1,  1'b0, 12'd20},
        '{4'd2,  9'd150, 5'd1,  1'b0, 12'd150},
        '{4'd3,  9'd256, 5'd15, 1'b0, 12'd3840},
        '{4'd3,  9'd250, 5'd1,  1'b0, 12'd4090},
        '{4'd3,  9'd100, 5'd1,  1'b0, 12'd94},  // Crosses the wrap.
        '{4'd1,  9'd20,  5'd1,  1'b0, 12'd40},
        '{4'd2,  9'd150, 5'd1,  1'b1, 12'd300},
        '{4'd3,  9'd201, 5'd2,  1'b1, 12'd496},
        '{4'd4,  9'd1,   5'd1,  1'b1, 12'd1},
        '{4'd15, 9'd64,  5'd1,  1'b1, 12'd64},
        '{4'd0,  9'd65,  5'd1,  1'b0, 12'd65}
    };

    logic       clk = 1'b0;
    logic       reset;
    logic       setup_done;
    logic       send_q_empty;
    send_req_t  send_q_rd_data;
    logic       send_q_rd_req;
    logic       payload_val;
    noc_data_t  payload_data;
    logic       payload_rdy;
    logic       noc_out_val;
    noc_data_t  noc_out_data;
    logic       noc_out_rdy;
    logic       ctrl_out_val;
    ctrl_data_t ctrl_out_data;
    logic       ctrl_out_rdy;

    logic [15:0]  lfsr = 16'd53116;
    payload_ptr_t ptr_model [NUM_FLOWS];
    noc_data_t    exp_flits [$];
    ctrl_data_t   exp_notifs [$];
    noc_data_t    pay_q [$];
    send_req_t    req_q [$];
    int           err_cnt = 0;
    int           fail_cnt = 0;
    int           notif_cnt = 0;
    int           cycles = 0;
    int           timeout_limit;
    int           pop_cycle = 0;
    logic         await_hdr = 1'b0;
    logic         stall_en = 1'b0;
    payload_ptr_t last_ptr = '0;

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_limit) begin
            $display("Timeout after %0d cycles, the engine stopped making progress", cycles);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    open_loop_tx_engine u_open_loop_tx_engine (.*);

    // Taps 16, 14, 13, 11.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic noc_data_t take_bits(input int n);
        noc_data_t bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            bits = {bits[NOC_DATA_W-2:0], lfsr[0]};
        end
        return bits;
    endfunction

    function automatic int msg_flits(input int size);
        int flits;
        int left;
        flits = 0;
        left  = size;
        while (left > 0) begin
            flits += 1 + ((left > MAX_PKT_BYTES ? MAX_PKT_BYTES : left) + 7) / BYTES_PER_FLIT;
            left  -= MAX_PKT_BYTES;
        end
        return flits;
    endfunction

    // Reference model: headers, payload words and notification of one message.
    task automatic queue_message(input flowid_t f, input msg_size_t size);
        int           left;
        int           n;
        int           nflits;
        payload_ptr_t p;
        buf_wr_hdr_t  h;
        tx_notif_t    nt;
        noc_data_t    w;
        left = int'(size);
        p    = ptr_model[f];
        while (left > 0) begin
            n            = (left > MAX_PKT_BYTES) ? MAX_PKT_BYTES : left;
            nflits       = (n + BYTES_PER_FLIT - 1) / BYTES_PER_FLIT;
            h            = '0;
            h.dst_x      = 4'd3;  // Buffer tile.
            h.dst_y      = 4'd0;
            h.src_x      = 4'd1;
            h.src_y      = 4'd2;
            h.flowid     = f;
            h.wr_ptr     = p;
            h.pkt_bytes  = pkt_bytes_t'(n);
            h.padbytes   = PADBYTES_W'(nflits * BYTES_PER_FLIT - n);
            h.data_flits = PKT_FLITS_W'(nflits);
            exp_flits.push_back(noc_data_t'(h));
            for (int k = 0; k < nflits; k++) begin
                w = take_bits(NOC_DATA_W);
                exp_flits.push_back(w);
                pay_q.push_back(w);
            end
            p    = p + payload_ptr_t'(n);
            left = left - n;
        end
        nt           = '0;
        nt.flowid    = f;
        nt.wr_ptr    = p;
        nt.size      = size;
        ptr_model[f] = p;
        exp_notifs.push_back(ctrl_data_t'(nt));
        req_q.push_back(send_req_t'{flowid: f, size: size});
    endtask

    // One clock cycle: sample at the falling edge, drive at the rising edge.
    task automatic step();
        logic      pay_hold;
        noc_data_t exp;
        tx_notif_t got;
        @(negedge clk);
        pay_hold = payload_val && !payload_rdy;
        if (await_hdr && noc_out_val) begin
            await_hdr = 1'b0;
            if (cycles - pop_cycle != 2) begin
                $display("** Error at %0t: pop to header latency expected 2, got %0d",
                         $time, cycles - pop_cycle);
                err_cnt++;
            end
        end
        if (send_q_rd_req) begin
            if (req_q.size() == 0) begin
                $display("Pop from an empty send queue at %0t", $time);
                err_cnt++;
            end else begin
                void'(req_q.pop_front());
            end
            pop_cycle = cycles;
            await_hdr = 1'b1;
        end
        if (noc_out_val && noc_out_rdy) begin
            if (exp_flits.size() == 0) begin
                $display("Unexpected NoC flit %h at %0t", noc_out_data, $time);
                err_cnt++;
            end else begin
                exp = exp_flits.pop_front();
                if (noc_out_data !== exp) begin
                    $display("** Error at %0t: noc_out_data expected %h, got %h",
                             $time, exp, noc_out_data);
                    err_cnt++;
                end
            end
        end
        if (ctrl_out_val && ctrl_out_rdy) begin
            got = ctrl_out_data;
            last_ptr = got.wr_ptr;
            notif_cnt++;
            if (exp_notifs.size() == 0) begin
                $display("Unexpected notification %h at %0t", ctrl_out_data, $time);
                err_cnt++;
            end else if (ctrl_out_data !== exp_notifs[0]) begin
                $display("** Error at %0t: ctrl_out_data expected %h, got %h",
                         $time, exp_notifs[0], ctrl_out_data);
                err_cnt++;
            end
            if (exp_notifs.size() != 0) begin
                void'(exp_notifs.pop_front());
            end
        end
        if (payload_val && payload_rdy) begin
            void'(pay_q.pop_front());
        end
        @(posedge clk);
        send_q_empty <= (req_q.size() == 0);
        if (req_q.size() != 0) begin
            send_q_rd_data <= req_q[0];
        end
        if (!pay_hold) begin
            payload_val <= 1'b0;
            if (pay_q.size() != 0 && (!stall_en || take_bits(2) != '0)) begin
                payload_val  <= 1'b1;  // Held until taken.
                payload_data <= pay_q[0];
            end
        end
        noc_out_rdy  <= 1'b1;
        ctrl_out_rdy <= 1'b1;
        if (stall_en) begin
            noc_out_rdy  <= (take_bits(2) != '0);
            ctrl_out_rdy <= (take_bits(2) != '0);
        end
    endtask

    initial begin
        int row_errs;
        int target;
        timeout_limit = 200;
        for (int r = 0; r < NUM_ROWS; r++) begin
            timeout_limit += 4 * (int'(rows[r].reps) * msg_flits(int'(rows[r].size)) + 4);
        end
        for (int i = 0; i < NUM_FLOWS; i++) begin
            ptr_model[i] = '0;
        end
        reset          = 1'b1;
        setup_done     = 1'b0;
        send_q_empty   = 1'b1;
        send_q_rd_data = '0;
        payload_val    = 1'b0;
        payload_data   = '0;
        noc_out_rdy    = 1'b1;
        ctrl_out_rdy   = 1'b1;
        repeat (4) @(posedge clk);
        reset          <= 1'b0;
        send_q_empty   <= 1'b0;  // Pending request that must wait for setup.
        send_q_rd_data <= '{flowid: 4'd5, size: 9'd8};

        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            if (send_q_rd_req || noc_out_val || ctrl_out_val || payload_rdy) begin
                $display("Output active at %0t before setup was done", $time);
                err_cnt++;
            end
        end
        @(posedge clk);
        send_q_empty <= 1'b1;
        setup_done   <= 1'b1;
        if (err_cnt != 0) begin
            fail_cnt++;
        end
        $display("test setup: %s", (err_cnt == 0) ? "passed" : "FAILED");

        for (int r = 0; r < NUM_ROWS; r++) begin
            row_errs = err_cnt;
            stall_en = rows[r].stall;
            for (int k = 0; k < int'(rows[r].reps); k++) begin
                queue_message(rows[r].flowid, rows[r].size);
            end
            target = notif_cnt + int'(rows[r].reps);
            while (notif_cnt < target) begin
                step();
            end
            if (last_ptr !== rows[r].exp_ptr) begin
                $display("** Error at %0t: ctrl_out_data.wr_ptr expected %0d, got %0d",
                         $time, rows[r].exp_ptr, last_ptr);
                err_cnt++;
            end
            if (exp_flits.size() != 0 || pay_q.size() != 0) begin
                $display("Row %0d ended with %0d flits still expected", r, exp_flits.size());
                err_cnt++;
            end
            if (err_cnt != row_errs) begin
                fail_cnt++;
            end
            $display("test %0d: flow %0d, %0d bytes x%0d, stall %0d: %s", r,
                     rows[r].flowid, rows[r].size, rows[r].reps, rows[r].stall,
                     (err_cnt == row_errs) ? "passed" : "FAILED");
        end

        $display("Tests run: %0d, tests failed: %0d, errors: %0d",
                 NUM_ROWS + 1, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- compile.f
src/tx_engine_pkg.sv
src/flow_state_table.sv
src/tx_engine_datap.sv
src/tx_engine_ctrl.sv
src/open_loop_tx_engine.sv
verification/open_loop_tx_engine_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the transmit engine testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f \
    --top-module open_loop_tx_engine_tb -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || echo "Build or simulation exited with an error" >> sim.log

cat sim.log
grep -q "STATUS: FAIL" sim.log && exit 1
grep -q "STATUS: PASS" sim.log || exit 1
exit 0
